/* build.f */
+incdir+logic
logic/rv_fetch_pkg.sv
logic/fetch_pc_unit.sv
logic/fetch_queue.sv
logic/decode_regfile.sv
logic/decode_stage.sv
logic/fetch_decode_top.sv
verif/imem_wb_model.sv
verif/fetch_decode_tb.sv

/* Bender.yml */
package:
  name: rv_fetch_decode

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_fetch_pkg.sv
      - logic/fetch_pc_unit.sv
      - logic/fetch_queue.sv
      - logic/decode_regfile.sv
      - logic/decode_stage.sv
      - logic/fetch_decode_top.sv

  - target: test
    include_dirs:
      - logic
    files:
      - verif/imem_wb_model.sv
      - verif/fetch_decode_tb.sv

/* verif/fetch_decode_tb.sv */
//**********************************************************
// testbench for the fetch and decode front end
// random program in the memory model, random write-back traffic,
// a cycle model of decode checked by immediate assertions
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module fetch_decode_tb;

    import rv_fetch_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_INSTR      = 250;
    localparam int          MEM_AW       = 10;
    localparam int          MAX_WAIT     = 3;
    localparam int unsigned SEED         = 32'h8f89201e;
    // worst fetch is request, wait states, ack and settle, doubled for stalls and refills
    localparam int          LIMIT_CYCLES = RESET_CYCLES + N_INSTR * (MAX_WAIT + 3) * 2;

    logic                clk;
    logic                rst_n;
    logic                imem_cyc;
    logic                imem_stb;
    logic                imem_we;
    logic [`RV_XLEN-1:0] imem_adr;
    logic [`RV_XLEN-1:0] imem_dat;
    logic                imem_ack;
    logic                pc_sel_w;
    logic [`RV_XLEN-1:0] alu_out_w;
    logic                rwe_w;
    logic [4:0]          rd_w;
    logic [`RV_XLEN-1:0] wb_data_w;
    logic                csr_we;
    logic [11:0]         csr_i_w;
    logic                jump_x;
    logic                stall;
    logic                dec_valid;
    logic [`RV_XLEN-1:0] dec_pc;
    logic [`RV_XLEN-1:0] dec_inst;
    logic [`RV_XLEN-1:0] rs1d;
    logic [`RV_XLEN-1:0] rs2d;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] csrd_tohost;

    // reference model state
    logic [`RV_XLEN-1:0] prog [2**MEM_AW];
    logic [`RV_XLEN-1:0] reg_mirror [`RV_NREGS];
    logic [`RV_XLEN-1:0] exp_pc;
    logic [`RV_XLEN-1:0] exp_tohost;
    logic [`RV_XLEN-1:0] exp_word;
    // what the previous edge allows at this edge
    logic                armed;
    logic                may_capture;
    logic                redirected;
    logic                jump_prev;
    logic                wb_wait_prev;
    logic                ack_prev;
    logic [`RV_XLEN-1:0] adr_prev;
    logic                h_valid;
    logic [`RV_XLEN-1:0] h_pc;
    logic [`RV_XLEN-1:0] h_inst;
    logic [`RV_XLEN-1:0] h_rs1;
    logic [`RV_XLEN-1:0] h_rs2;
    logic [`RV_XLEN-1:0] h_imm;
    int                  errs_proto;
    int                  errs_fetch;
    int                  errs_dec;
    int                  errs_host;
    int                  decoded;

    fetch_decode_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_cyc    (imem_cyc),
        .imem_stb    (imem_stb),
        .imem_we     (imem_we),
        .imem_adr    (imem_adr),
        .imem_dat_i  (imem_dat),
        .imem_ack    (imem_ack),
        .pc_sel_w    (pc_sel_w),
        .alu_out_w   (alu_out_w),
        .rwe_w       (rwe_w),
        .rd_w        (rd_w),
        .wb_data_w   (wb_data_w),
        .csr_we      (csr_we),
        .csr_i_w     (csr_i_w),
        .jump_x      (jump_x),
        .stall       (stall),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .rs1d        (rs1d),
        .rs2d        (rs2d),
        .imm         (imm),
        .csrd_tohost (csrd_tohost)
    );

    imem_wb_model #(
        .AW       (MEM_AW),
        .MAX_WAIT (MAX_WAIT)
    ) imem (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (imem_cyc),
        .stb   (imem_stb),
        .we    (imem_we),
        .adr   (imem_adr),
        .dat_o (imem_dat),
        .ack   (imem_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [`RV_XLEN-1:0] exp_v,
                               input logic [`RV_XLEN-1:0] act_v, inout int cnt);
        assert (act_v === exp_v) else begin
            cnt++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        end
    endtask

    // immediate per rv32i encoding, sign taken from bit 31
    function automatic logic [`RV_XLEN-1:0] ref_imm(input logic [`RV_XLEN-1:0] w);
        logic [`RV_XLEN-1:0] r;
        case (w[6:0])
            OP_IMM, LOAD, JALR, SYSTEM: r = $signed(w[31:20]);
            STORE:      r = $signed({w[31:25], w[11:7]});
            BRANCH:     r = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            LUI, AUIPC: r = w & 32'hFFFF_F000;
            JAL:        r = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            default:    r = '0;
        endcase
        return r;
    endfunction

    // random fields under one of the rv32i major opcodes
    function automatic logic [`RV_XLEN-1:0] random_instr();
        logic [`RV_XLEN-1:0] w;
        opcode_e             op;
        w = $urandom;
        case ($urandom_range(9, 0))
            0:       op = OP_IMM;
            1:       op = LOAD;
            2:       op = STORE;
            3:       op = BRANCH;
            4:       op = JAL;
            5:       op = JALR;
            6:       op = LUI;
            7:       op = AUIPC;
            8:       op = SYSTEM;
            default: op = OP;
        endcase
        w[6:0] = op;
        return w;
    endfunction

    task automatic load_program();
        for (int i = 0; i < 2**MEM_AW; i++) begin
            prog[i] = random_instr();
            imem.load_word(i, prog[i]);
        end
    endtask

    task automatic drive_random_inputs();
        logic [`RV_XLEN-1:0] addr_bits;
        addr_bits = $urandom;
        stall     = ($urandom_range(99, 0) < 20);
        jump_x    = ($urandom_range(99, 0) < 10);
        pc_sel_w  = ($urandom_range(99, 0) < 2);
        // word aligned target inside the program
        alu_out_w = $urandom_range(2**MEM_AW - 1, 0) * 4;
        rwe_w     = ($urandom_range(99, 0) < 40);
        rd_w      = $urandom_range(31, 0);
        wb_data_w = $urandom;
        csr_we    = ($urandom_range(99, 0) < 10);
        // half the csr writes miss tohost
        csr_i_w   = $urandom_range(1, 0) ? `RV_CSR_TOHOST : addr_bits[11:0];
    endtask

    // cycle model, pre-edge outputs checked against the previous edge
    always @(posedge clk) begin
        if (!rst_n) begin
            armed        = 1'b0;
            may_capture  = 1'b0;
            redirected   = 1'b0;
            wb_wait_prev = 1'b0;
            ack_prev     = 1'b0;
            exp_pc       = `RV_RESET_PC;
            exp_tohost   = '0;
            for (int i = 0; i < `RV_NREGS; i++)
                reg_mirror[i] = '0;
        end else begin
            check_value("imem_we", '0, imem_we, errs_proto);
            // stb and adr hold until ack, then stb drops
            if (wb_wait_prev) begin
                check_value("imem_stb", 1, imem_stb, errs_proto);
                check_value("imem_cyc", 1, imem_cyc, errs_proto);
                check_value("imem_adr", adr_prev, imem_adr, errs_proto);
            end
            if (ack_prev)
                check_value("imem_stb", 0, imem_stb, errs_proto);
            check_value("csrd_tohost", exp_tohost, csrd_tohost, errs_host);
            if (!armed) begin
                // reset values
                check_value("dec_valid", 0, dec_valid, errs_dec);
                check_value("imem_cyc", 0, imem_cyc, errs_proto);
            end else if (may_capture && dec_valid) begin
                decoded++;
                exp_word = jump_prev ? `RV_INSTR_NOP : prog[exp_pc[MEM_AW+1:2]];
                check_value("dec_pc", exp_pc, dec_pc, errs_fetch);
                check_value("dec_inst", exp_word, dec_inst, errs_fetch);
                check_value("imm", ref_imm(exp_word), imm, errs_dec);
                // mirror already holds the write of the capture edge
                check_value("rs1d", reg_mirror[exp_word[19:15]], rs1d, errs_dec);
                check_value("rs2d", reg_mirror[exp_word[24:20]], rs2d, errs_dec);
                exp_pc = exp_pc + 4;
            end else begin
                // no capture, so every decode output holds
                if (redirected)
                    check_value("dec_valid", 0, dec_valid, errs_dec);
                else if (!may_capture)
                    check_value("dec_valid", h_valid, dec_valid, errs_dec);
                check_value("dec_pc", h_pc, dec_pc, errs_dec);
                check_value("dec_inst", h_inst, dec_inst, errs_dec);
                check_value("rs1d", h_rs1, rs1d, errs_dec);
                check_value("rs2d", h_rs2, rs2d, errs_dec);
                check_value("imm", h_imm, imm, errs_dec);
            end
            // this edge's write-back traffic
            if (rwe_w && (rd_w != 5'd0))
                reg_mirror[rd_w] = wb_data_w;
            if (csr_we && (csr_i_w == `RV_CSR_TOHOST))
                exp_tohost = wb_data_w;
            if (pc_sel_w)
                exp_pc = alu_out_w;
            may_capture  = !stall && !pc_sel_w;
            redirected   = pc_sel_w;
            jump_prev    = jump_x;
            wb_wait_prev = imem_cyc && imem_stb && !imem_ack;
            ack_prev     = imem_stb && imem_ack;
            adr_prev     = imem_adr;
            h_valid      = dec_valid;
            h_pc         = dec_pc;
            h_inst       = dec_inst;
            h_rs1        = rs1d;
            h_rs2        = rs2d;
            h_imm        = imm;
            armed        = 1'b1;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        jump_x     = 1'b0;
        pc_sel_w   = 1'b0;
        alu_out_w  = '0;
        rwe_w      = 1'b0;
        rd_w       = '0;
        wb_data_w  = '0;
        csr_we     = 1'b0;
        csr_i_w    = '0;
        errs_proto = 0;
        errs_fetch = 0;
        errs_dec   = 0;
        errs_host  = 0;
        decoded    = 0;
        void'($urandom(SEED));
        load_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        // run until decode has handed enough words to execute
        while (decoded < N_INSTR) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_random_inputs();
        end
        @(posedge clk);
        $display("errors: protocol %0d, fetch %0d, decode %0d, tohost %0d in %0d instructions",
                 errs_proto, errs_fetch, errs_dec, errs_host, decoded);
        if ((errs_proto + errs_fetch + errs_dec + errs_host) == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    // hang guard
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog expired, only %0d of %0d instructions decoded in %0d cycles",
                 decoded, N_INSTR, LIMIT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/imem_wb_model.sv */
//**********************************************************
// wishbone classic slave memory for the fetch testbench
// read only, random wait states, filled through load_word
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module imem_wb_model #(
    parameter int AW       = 10,
    parameter int MAX_WAIT = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cyc,
    input  logic                stb,
    input  logic                we,
    input  logic [`RV_XLEN-1:0] adr,
    output logic [`RV_XLEN-1:0] dat_o,
    output logic                ack
);

    // word array, byte address bits [1:0] ignored
    logic [`RV_XLEN-1:0] mem [2**AW];
    int unsigned         wait_left;

    // backdoor fill from the testbench before reset ends
    task automatic load_word(input int unsigned idx, input logic [`RV_XLEN-1:0] word);
        mem[idx] = word;
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            dat_o     <= '0;
            wait_left <= 0;
        end else begin
            // ack is a single cycle pulse
            ack <= 1'b0;
            if (cyc && stb && !we && !ack) begin
                if (wait_left == 0) begin
                    ack       <= 1'b1;
                    dat_o     <= mem[adr[AW+1:2]];
                    // new latency for the next transfer
                    wait_left <= $urandom_range(MAX_WAIT, 0);
                end else begin
                    wait_left <= wait_left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/fetch_decode_top.sv */
//**********************************************************
// fetch and decode front end, fetch unit -> queue -> decode
// instruction memory hangs off the wishbone classic port
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module fetch_decode_top (
    input  logic                clk,
    input  logic                rst_n,
    // instruction memory, wishbone classic
    output logic                imem_cyc,
    output logic                imem_stb,
    output logic                imem_we,
    output logic [`RV_XLEN-1:0] imem_adr,
    input  logic [`RV_XLEN-1:0] imem_dat_i,
    input  logic                imem_ack,
    // from write-back
    input  logic                pc_sel_w,
    input  logic [`RV_XLEN-1:0] alu_out_w,
    input  logic                rwe_w,
    input  logic [4:0]          rd_w,
    input  logic [`RV_XLEN-1:0] wb_data_w,
    input  logic                csr_we,
    input  logic [11:0]         csr_i_w,
    // from execute
    input  logic                jump_x,
    input  logic                stall,
    // to execute
    output logic                dec_valid,
    output logic [`RV_XLEN-1:0] dec_pc,
    output logic [`RV_XLEN-1:0] dec_inst,
    output logic [`RV_XLEN-1:0] rs1d,
    output logic [`RV_XLEN-1:0] rs2d,
    output logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] csrd_tohost
);

    import rv_fetch_pkg::*;

    fetch_pkt_t push_data;
    fetch_pkt_t pop_data;
    logic       push;
    logic       pop;
    logic       empty;
    logic [2:0] free_slots;

    fetch_pc_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_sel      (pc_sel_w),
        .redirect_pc (alu_out_w),
        .queue_free  (free_slots),
        .imem_cyc    (imem_cyc),
        .imem_stb    (imem_stb),
        .imem_we     (imem_we),
        .imem_adr    (imem_adr),
        .imem_dat_i  (imem_dat_i),
        .imem_ack    (imem_ack),
        .push        (push),
        .push_data   (push_data)
    );

    // redirect from write-back flushes everything queued
    fetch_queue #(
        .payload_t (fetch_pkt_t),
        .DEPTH     (`RV_FQ_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (pc_sel_w),
        .push       (push),
        .pop        (pop),
        .push_data  (push_data),
        .pop_data   (pop_data),
        .empty      (empty),
        .full       (),
        .free_slots (free_slots)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .jump_x      (jump_x),
        .pc_sel      (pc_sel_w),
        .empty       (empty),
        .pop_data    (pop_data),
        .pop         (pop),
        .rwe_w       (rwe_w),
        .rd_w        (rd_w),
        .wb_data_w   (wb_data_w),
        .csr_we      (csr_we),
        .csr_i_w     (csr_i_w),
        .dec_valid   (dec_valid),
        .dec_pc      (dec_pc),
        .dec_inst    (dec_inst),
        .rs1d        (rs1d),
        .rs2d        (rs2d),
        .imm         (imm),
        .csrd_tohost (csrd_tohost)
    );

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
//**********************************************************
// decode stage, pops fetch packets and registers operands to execute
// also holds the tohost csr written from write-back
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module decode_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      stall,
    input  logic                      jump_x,
    input  logic                      pc_sel,
    input  logic                      empty,
    input  rv_fetch_pkg::fetch_pkt_t  pop_data,
    output logic                      pop,
    input  logic                      rwe_w,
    input  logic [4:0]                rd_w,
    input  logic [`RV_XLEN-1:0]       wb_data_w,
    input  logic                      csr_we,
    input  logic [11:0]               csr_i_w,
    output logic                      dec_valid,
    output logic [`RV_XLEN-1:0]       dec_pc,
    output logic [`RV_XLEN-1:0]       dec_inst,
    output logic [`RV_XLEN-1:0]       rs1d,
    output logic [`RV_XLEN-1:0]       rs2d,
    output logic [`RV_XLEN-1:0]       imm,
    output logic [`RV_XLEN-1:0]       csrd_tohost
);

    import rv_fetch_pkg::*;

    logic [`RV_XLEN-1:0] inst_sel;
    logic [`RV_XLEN-1:0] imm_c;
    logic [`RV_XLEN-1:0] rf_rs1d;
    logic [`RV_XLEN-1:0] rf_rs2d;
    opcode_e             opcode;
    imm_fmt_e            fmt;
    logic                capture;

    // taken jump in execute squashes the head word to a nop
    // everything below decodes the squashed word, so imm and reads go to zero
    assign inst_sel = jump_x ? `RV_INSTR_NOP : pop_data.inst;
    assign opcode   = opcode_e'(inst_sel[6:0]);

    // no pop on a redirect edge, the queue is flushed anyway
    assign pop     = !stall && !empty && !pc_sel;
    assign capture = pop;

    always_comb begin
        case (opcode)
            OP_IMM, LOAD, JALR, SYSTEM: fmt = IMM_I;
            STORE:                      fmt = IMM_S;
            BRANCH:                     fmt = IMM_B;
            LUI, AUIPC:                 fmt = IMM_U;
            JAL:                        fmt = IMM_J;
            default:                    fmt = IMM_NONE;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (fmt)
            IMM_I: imm_c = {{(`RV_XLEN-12){inst_sel[31]}}, inst_sel[31:20]};
            IMM_S: imm_c = {{(`RV_XLEN-12){inst_sel[31]}}, inst_sel[31:25], inst_sel[11:7]};
            IMM_B: imm_c = {{(`RV_XLEN-13){inst_sel[31]}}, inst_sel[31], inst_sel[7],
                            inst_sel[30:25], inst_sel[11:8], 1'b0};
            IMM_U: imm_c = {inst_sel[31:12], 12'b0};
            IMM_J: imm_c = {{(`RV_XLEN-21){inst_sel[31]}}, inst_sel[31], inst_sel[19:12],
                            inst_sel[20], inst_sel[30:21], 1'b0};
            default: imm_c = '0;
        endcase
    end

    decode_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rwe_w),
        .rs1   (inst_sel[19:15]),
        .rs2   (inst_sel[24:20]),
        .rd    (rd_w),
        .wd    (wb_data_w),
        .rs1d  (rf_rs1d),
        .rs2d  (rf_rs2d)
    );

    // valid drops on redirect or on an empty queue, holds under stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dec_valid <= 1'b0;
        else if (pc_sel)
            dec_valid <= 1'b0;
        else if (!stall)
            dec_valid <= !empty;
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            dec_pc   <= pop_data.pc;
            dec_inst <= inst_sel;
            rs1d     <= rf_rs1d;
            rs2d     <= rf_rs2d;
            imm      <= imm_c;
        end
    end

    // tohost ignores stall, write-back owns it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            csrd_tohost <= '0;
        else if (csr_we && (csr_i_w == `RV_CSR_TOHOST))
            csrd_tohost <= wb_data_w;
    end

endmodule

`default_nettype wire

/* logic/decode_regfile.sv */
//**********************************************************
// 32 entry integer register file for the decode stage
// two combinational reads, same-cycle write is forwarded
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module decode_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] wd,
    output logic [`RV_XLEN-1:0] rs1d,
    output logic [`RV_XLEN-1:0] rs2d
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;
        end
    end

    // read port 1
    always_comb begin
        if (rs1 == 5'd0)
            rs1d = '0;
        else if (we && (rd == rs1))
            // write-back value bypasses the array
            rs1d = wd;
        else
            rs1d = regs[rs1];
    end

    // read port 2, same forwarding as port 1
    always_comb begin
        if (rs2 == 5'd0)
            rs2d = '0;
        else if (we && (rd == rs2))
            rs2d = wd;
        else
            rs2d = regs[rs2];
    end

endmodule

`default_nettype wire

/* logic/fetch_queue.sv */
//**********************************************************
// small synchronous fifo between fetch and decode
// payload type is a parameter, head is visible without delay
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module fetch_queue #(
    parameter type payload_t = logic [`RV_XLEN-1:0],
    parameter int  DEPTH     = `RV_FQ_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     push,
    input  logic     pop,
    input  payload_t push_data,
    output payload_t pop_data,
    output logic     empty,
    output logic     full,
    output logic [2:0] free_slots
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            do_push;
    logic            do_pop;

    // refused operations are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // one-cycle clear on redirect
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !flush)
            mem[wr_ptr] <= push_data;
    end

    assign pop_data   = mem[rd_ptr];
    assign empty      = (count == '0);
    assign full       = (count == CW'(DEPTH));
    // lets the producer reserve room before starting a fetch
    assign free_slots = 3'(DEPTH - int'(count));

endmodule

`default_nettype wire

/* logic/fetch_pc_unit.sv */
//**********************************************************
// program counter and wishbone classic instruction fetch master
// pushes {pc, word} pairs into the fetch queue, one per cycle pair
//**********************************************************

`timescale 1ns/100ps
`default_nettype none

`include "rv_fetch_macros.svh"

module fetch_pc_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pc_sel,
    input  logic [`RV_XLEN-1:0]       redirect_pc,
    input  logic [2:0]                queue_free,
    output logic                      imem_cyc,
    output logic                      imem_stb,
    output logic                      imem_we,
    output logic [`RV_XLEN-1:0]       imem_adr,
    input  logic [`RV_XLEN-1:0]       imem_dat_i,
    input  logic                      imem_ack,
    output logic                      push,
    output rv_fetch_pkg::fetch_pkt_t  push_data
);

    // settle keeps stb low for one cycle after every ack
    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_SETTLE
    } wb_state_e;

    wb_state_e           state;
    wb_state_e           state_nxt;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] req_adr;
    logic                drop;
    logic                ack_seen;
    logic                can_start;

    assign ack_seen  = (state == S_REQ) && imem_ack;
    // no new request on a redirect edge, pc is about to move
    assign can_start = (queue_free != 3'd0) && !pc_sel;

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE:   if (can_start) state_nxt = S_REQ;
            // a started transfer always runs to its ack
            S_REQ:    if (imem_ack) state_nxt = S_SETTLE;
            S_SETTLE: state_nxt = can_start ? S_REQ : S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
            pc    <= `RV_RESET_PC;
            drop  <= 1'b0;
        end else begin
            state <= state_nxt;
            // write-back redirect wins over sequential advance
            if (pc_sel)
                pc <= redirect_pc;
            else if (ack_seen && !drop)
                pc <= pc + `RV_XLEN'd4;
            // redirect while waiting, the stale word must not be queued
            if ((state == S_REQ) && pc_sel && !imem_ack)
                drop <= 1'b1;
            else if (ack_seen)
                drop <= 1'b0;
        end
    end

    // address latched at request start, stable until ack
    always_ff @(posedge clk) begin
        if ((state_nxt == S_REQ) && (state != S_REQ))
            req_adr <= pc;
    end

    assign imem_cyc = (state == S_REQ);
    assign imem_stb = (state == S_REQ);
    // read only port
    assign imem_we  = 1'b0;
    assign imem_adr = req_adr;

    // data is captured by the queue on the ack edge
    assign push           = ack_seen && !drop && !pc_sel;
    assign push_data.pc   = req_adr;
    assign push_data.inst = imem_dat_i;

endmodule

`default_nettype wire

/* logic/rv_fetch_pkg.sv */
//**********************************************************
// types shared by the fetch unit, the fetch queue and decode
// compile before any module of the front end
//**********************************************************

`default_nettype none

`include "rv_fetch_macros.svh"

package rv_fetch_pkg;

    // one fetched word together with the address it came from
    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [`RV_XLEN-1:0] inst;
    } fetch_pkt_t;

    // rv32i major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        LOAD   = 7'b000_0011,
        OP_IMM = 7'b001_0011,
        AUIPC  = 7'b001_0111,
        STORE  = 7'b010_0011,
        OP     = 7'b011_0011,
        LUI    = 7'b011_0111,
        BRANCH = 7'b110_0011,
        JALR   = 7'b110_0111,
        JAL    = 7'b110_1111,
        SYSTEM = 7'b111_0011
    } opcode_e;

    // immediate layouts, NONE for register-register ops
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } imm_fmt_e;

endpackage

`default_nettype wire

/* logic/rv_fetch_macros.svh */
//**********************************************************
// shared widths and constants for the rv32i fetch/decode front end
// include wherever a width, the nop word or the reset pc is needed
//**********************************************************

`ifndef RV_FETCH_MACROS_SVH
`define RV_FETCH_MACROS_SVH

// data and address width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NREGS 32

// default fetch queue depth, keep it a power of two
`define RV_FQ_DEPTH 4

// addi x0,x0,0
`define RV_INSTR_NOP 32'h0000_0013

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// tohost csr address
`define RV_CSR_TOHOST 12'h51E

`endif
